// ==== tb.f ====
common/mem_pkg.sv
src/sram_port.sv
src/mem_router.sv
ram1/ram_uart.sv
ram2/ram2_arbiter.sv
src/mem_subsystem.sv
dv/ext_models.sv
dv/mem_subsystem_assert.sv
dv/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/bash
# build and run with Verilator; pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_mem_subsystem \
	--Mdir obj_dir -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== dv/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

	typedef enum logic [2:0] {
		op_rd,
		op_wr,
		op_fetch,
		op_stat,
		op_both
	} op_t;

	typedef struct packed {
		op_t                op;
		mem_pkg::mem_word_t addr;
		mem_pkg::mem_word_t wdata;
		mem_pkg::mem_word_t expect_v;
	} entry_t;

	localparam int n_tests = 13;

	logic clk;
	logic rst_n;
	mem_pkg::mem_req_t exe_req;
	logic fetch_req;
	mem_pkg::mem_word_t fetch_addr;
	logic data_ready;
	logic tbre;
	logic tsre;
	mem_pkg::mem_word_t ram1_rdata;
	mem_pkg::mem_word_t ram2_rdata;
	mem_pkg::mem_word_t sram1_q;
	logic hold;
	mem_pkg::mem_word_t exe_rdata;
	logic fetch_done;
	mem_pkg::mem_word_t fetch_inst;
	mem_pkg::sram_pins_t ram1_pins;
	mem_pkg::sram_pins_t ram2_pins;
	logic rdn;
	logic wrn;
	logic [7:0] rx_byte;

	entry_t tests [n_tests];
	int errors;
	int checks;

	mem_subsystem dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.exe_req    (exe_req),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.data_ready (data_ready),
		.tbre       (tbre),
		.tsre       (tsre),
		.ram1_rdata (ram1_rdata),
		.ram2_rdata (ram2_rdata),
		.hold       (hold),
		.exe_rdata  (exe_rdata),
		.fetch_done (fetch_done),
		.fetch_inst (fetch_inst),
		.ram1_pins  (ram1_pins),
		.ram2_pins  (ram2_pins),
		.rdn        (rdn),
		.wrn        (wrn)
	);

	sram_model ram1_m (.clk(clk), .pins(ram1_pins), .rdata(sram1_q));
	sram_model ram2_m (.clk(clk), .pins(ram2_pins), .rdata(ram2_rdata));

	uart_model uart_m (
		.clk        (clk),
		.rst_n      (rst_n),
		.rdn        (rdn),
		.wrn        (wrn),
		.bus_wdata  (ram1_pins.wdata),
		.rx_byte    (rx_byte),
		.data_ready (data_ready),
		.tbre       (tbre),
		.tsre       (tsre)
	);

	// uart drives the SRAM 1 bus while rdn is low
	assign ram1_rdata = rdn ? sram1_q : {8'h00, rx_byte};

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(n_tests * 40 * 4);
		$display("timeout: the tests did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

	// untouched SRAM word
	function automatic mem_pkg::mem_word_t fill_word(input mem_pkg::mem_word_t a);
		return a ^ 16'ha5c3;
	endfunction

	task automatic check_word(input string name, input mem_pkg::mem_word_t got,
			input mem_pkg::mem_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	initial begin
		entry_t ent;
		mem_pkg::mem_word_t exe_got;
		mem_pkg::mem_word_t fetch_got;
		logic exe_wait;
		logic fetch_wait;
		int err_before;

		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		exe_req = '0;
		fetch_req = 1'b0;
		fetch_addr = '0;

		// op, address, write data, expected value
		tests[0]  = '{op_wr,    16'h9000, 16'h1234, 16'h1234};
		tests[1]  = '{op_rd,    16'h9000, 16'h0000, 16'h1234};
		tests[2]  = '{op_wr,    16'h0040, 16'hbeef, 16'hbeef};
		tests[3]  = '{op_rd,    16'h0040, 16'h0000, 16'hbeef};
		tests[4]  = '{op_fetch, 16'h0040, 16'h0000, 16'hbeef};
		// first byte already waiting, transmitter idle
		tests[5]  = '{op_stat,  mem_pkg::uart_stat_addr, 16'h0000, 16'h0003};
		tests[6]  = '{op_rd,    mem_pkg::uart_data_addr, 16'h0000, 16'h003c};
		tests[7]  = '{op_rd,    mem_pkg::uart_data_addr, 16'h0000, 16'h00a7};
		tests[8]  = '{op_wr,    mem_pkg::uart_data_addr, 16'h5a66, 16'h0066};
		tests[9]  = '{op_both,  16'h0050, 16'hc0de, 16'hc0de};
		tests[10] = '{op_rd,    16'h0050, 16'h0000, 16'hc0de};
		tests[11] = '{op_fetch, 16'h1000, 16'h0000, fill_word(16'h1000)};
		// receive queue drained, transmitter idle again
		tests[12] = '{op_stat,  mem_pkg::uart_stat_addr, 16'h0000, 16'h0001};

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		check_bit("hold", hold, 1'b0);
		check_bit("ram1_pins.en", ram1_pins.en, 1'b1);
		check_bit("ram2_pins.en", ram2_pins.en, 1'b1);
		check_bit("rdn", rdn, 1'b1);
		check_bit("wrn", wrn, 1'b1);
		$display("test reset: %s", (errors == 0) ? "ok" : "failed");

		for (int i = 0; i < n_tests; i++) begin
			ent = tests[i];
			err_before = errors;
			exe_wait = 1'b0;
			fetch_wait = 1'b0;
			exe_got = '0;
			fetch_got = '0;
			if (ent.op != op_fetch) begin
				exe_req.rd = (ent.op == op_rd) || (ent.op == op_stat);
				exe_req.wr = (ent.op == op_wr) || (ent.op == op_both);
				exe_req.addr = ent.addr;
				exe_req.wdata = ent.wdata;
				exe_wait = 1'b1;
			end
			if (ent.op == op_fetch || ent.op == op_both) begin
				fetch_req = 1'b1;
				fetch_addr = ent.addr;
				fetch_wait = 1'b1;
			end
			while (exe_wait || fetch_wait) begin
				@(negedge clk);
				if (exe_wait && !hold) begin
					exe_wait = 1'b0;
					exe_got = exe_rdata;
					exe_req = '0;
				end
				if (fetch_wait && fetch_done) begin
					fetch_wait = 1'b0;
					fetch_got = fetch_inst;
					fetch_req = 1'b0;
				end
			end

			case (ent.op)
				op_rd, op_stat: check_word("exe_rdata", exe_got, ent.expect_v);
				op_fetch: check_word("fetch_inst", fetch_got, ent.expect_v);
				default: begin
					if (ent.op == op_both) begin
						check_word("fetch_inst", fetch_got, ent.expect_v);
					end
					if (ent.addr == mem_pkg::uart_data_addr) begin
						check_word("uart tx byte", {8'h00, uart_m.last_tx}, ent.expect_v);
					end else if (ent.addr >= mem_pkg::ram1_base) begin
						check_word("sram1 word", ram1_m.mem[ent.addr], ent.expect_v);
						check_word("sram2 word", ram2_m.mem[ent.addr], fill_word(ent.addr));
					end else begin
						check_word("sram2 word", ram2_m.mem[ent.addr], ent.expect_v);
						check_word("sram1 word", ram1_m.mem[ent.addr], fill_word(ent.addr));
					end
				end
			endcase
			// fetch_done lasts a single cycle
			@(negedge clk);
			check_bit("fetch_done", fetch_done, 1'b0);
			$display("test %0d op %s addr %h: %s", i, ent.op.name(), ent.addr,
				(errors == err_before) ? "ok" : "failed");
		end

		$display("%0d tests, %0d checks, %0d errors", n_tests + 1, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/mem_subsystem_assert.sv ====
`timescale 1ns/1ps

module mem_subsystem_assert (
	input logic clk,
	input logic rst_n,
	input logic hold,
	input logic done,
	input logic start,
	input logic busy,
	input logic rdn,
	input logic wrn,
	input logic en,
	input logic oe,
	input logic rw
);

	hold_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(hold) |-> $past(done))
		else $error("hold fell without a done in the cycle before");

	uart_strobes: assert property (@(posedge clk) disable iff (!rst_n)
		!(!rdn && !wrn))
		else $error("rdn and wrn low together");

	sram_conflict: assert property (@(posedge clk) disable iff (!rst_n)
		!(!en && !oe && !rw))
		else $error("SRAM enabled with oe and rw both low");

	start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy)
		else $error("start while busy");

endmodule

bind mem_router mem_subsystem_assert router_chk_i (
	.clk   (clk),
	.rst_n (rst_n),
	.hold  (hold),
	.done  (done),
	.start (start),
	.busy  (busy),
	.rdn   (1'b1),
	.wrn   (1'b1),
	.en    (1'b1),
	.oe    (1'b1),
	.rw    (1'b1)
);

bind ram_uart mem_subsystem_assert ram_uart_chk_i (
	.clk   (clk),
	.rst_n (rst_n),
	.hold  (1'b0),
	.done  (rsp.done),
	.start (start),
	.busy  (state != st_idle),
	.rdn   (rdn),
	.wrn   (wrn),
	.en    (pins.en),
	.oe    (pins.oe),
	.rw    (pins.rw)
);

// ==== dv/ext_models.sv ====
`timescale 1ns/1ps

// asynchronous-read SRAM, written while en and rw are low and the bus is driven
module sram_model (
	input  logic                clk,
	input  mem_pkg::sram_pins_t pins,
	output mem_pkg::mem_word_t  rdata
);

	mem_pkg::mem_word_t mem [0:65535];

	// fill depends on the whole index
	initial begin
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 16'(i) ^ 16'ha5c3;
		end
	end

	assign rdata = mem[pins.addr[15:0]];

	always @(posedge clk) begin
		if (!pins.en && !pins.rw && pins.drive) begin
			mem[pins.addr[15:0]] <= pins.wdata;
		end
	end

endmodule

// uart with a receive queue and a short transmit countdown
module uart_model (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               rdn,
	input  logic               wrn,
	input  mem_pkg::mem_word_t bus_wdata,
	output logic [7:0]         rx_byte,
	output logic               data_ready,
	output logic               tbre,
	output logic               tsre
);

	integer seed;
	logic [7:0] rx_q [$];
	logic [7:0] last_tx;
	logic rdn_q;
	logic wrn_q;
	int delay;
	int tx_cnt;

	initial begin
		seed = 32'hf2a14a27;
		rx_q.push_back(8'h3c);
		rx_q.push_back(8'ha7);
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			data_ready <= 1'b0;
			rx_byte <= 8'h00;
			last_tx <= 8'h00;
			rdn_q <= 1'b1;
			wrn_q <= 1'b1;
			tbre <= 1'b1;
			tsre <= 1'b1;
			tx_cnt <= 0;
			delay <= $random(seed) & 7;
		end else begin
			rdn_q <= rdn;
			wrn_q <= wrn;
			// byte consumed when rdn rises
			if (!rdn_q && rdn) begin
				data_ready <= 1'b0;
				void'(rx_q.pop_front());
				delay <= ($random(seed) & 7) + 1;
			end else if (!data_ready && rx_q.size() != 0) begin
				if (delay == 0) begin
					rx_byte <= rx_q[0];
					data_ready <= 1'b1;
				end else begin
					delay <= delay - 1;
				end
			end
			if (wrn_q && !wrn) begin
				last_tx <= bus_wdata[7:0];
				tbre <= 1'b0;
				tsre <= 1'b0;
				tx_cnt <= 4;
			end else if (tx_cnt != 0) begin
				tx_cnt <= tx_cnt - 1;
				if (tx_cnt == 2) begin
					tbre <= 1'b1;
				end
				if (tx_cnt == 1) begin
					tsre <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
	input  logic                clk,
	input  logic                rst_n,
	input  mem_pkg::mem_req_t   exe_req,
	input  logic                fetch_req,
	input  mem_pkg::mem_word_t  fetch_addr,
	input  logic                data_ready,
	input  logic                tbre,
	input  logic                tsre,
	input  mem_pkg::mem_word_t  ram1_rdata,
	input  mem_pkg::mem_word_t  ram2_rdata,
	output logic                hold,
	output mem_pkg::mem_word_t  exe_rdata,
	output logic                fetch_done,
	output mem_pkg::mem_word_t  fetch_inst,
	output mem_pkg::sram_pins_t ram1_pins,
	output mem_pkg::sram_pins_t ram2_pins,
	output logic                rdn,
	output logic                wrn
);

	logic ram1_start;
	logic ram2_start;
	logic port_start;
	mem_pkg::ram_sel_t ram1_sel;
	mem_pkg::mem_rsp_t ram1_rsp;
	mem_pkg::mem_rsp_t ram2_rsp;
	mem_pkg::mem_rsp_t port_rsp;
	mem_pkg::mem_req_t port_req;

	mem_router router_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.exe_req    (exe_req),
		.ram1_rsp   (ram1_rsp),
		.ram2_rsp   (ram2_rsp),
		.ram1_start (ram1_start),
		.ram1_sel   (ram1_sel),
		.ram2_start (ram2_start),
		.hold       (hold),
		.exe_rdata  (exe_rdata)
	);

	// SRAM 1 and uart
	ram_uart ram_uart_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (ram1_start),
		.sel        (ram1_sel),
		.req        (exe_req),
		.ram_rdata  (ram1_rdata),
		.data_ready (data_ready),
		.tbre       (tbre),
		.tsre       (tsre),
		.rsp        (ram1_rsp),
		.pins       (ram1_pins),
		.rdn        (rdn),
		.wrn        (wrn)
	);

	// SRAM 2, shared by execute and fetch
	ram2_arbiter ram2_arbiter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.exe_start  (ram2_start),
		.exe_req    (exe_req),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.port_rsp   (port_rsp),
		.port_start (port_start),
		.port_req   (port_req),
		.exe_rsp    (ram2_rsp),
		.fetch_done (fetch_done),
		.fetch_inst (fetch_inst)
	);

	sram_port ram2_port_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (port_start),
		.req       (port_req),
		.ram_rdata (ram2_rdata),
		.rsp       (port_rsp),
		.pins      (ram2_pins)
	);

endmodule

// ==== ram2/ram2_arbiter.sv ====
`timescale 1ns/1ps

module ram2_arbiter (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               exe_start,
	input  mem_pkg::mem_req_t  exe_req,
	input  logic               fetch_req,
	input  mem_pkg::mem_word_t fetch_addr,
	input  mem_pkg::mem_rsp_t  port_rsp,
	output logic               port_start,
	output mem_pkg::mem_req_t  port_req,
	output mem_pkg::mem_rsp_t  exe_rsp,
	output logic               fetch_done,
	output mem_pkg::mem_word_t fetch_inst
);

	typedef enum logic [1:0] {
		gnt_none,
		gnt_exe,
		gnt_fetch
	} grant_t;

	grant_t grant;
	logic exe_pend;
	logic exe_go;
	logic fetch_go;
	logic fetch_done_q;
	mem_pkg::mem_req_t exe_req_q;
	mem_pkg::mem_req_t fetch_rd;

	// execute wins, also when it shows up in the same cycle as fetch
	assign exe_go = exe_start | exe_pend;
	// skip one cycle after fetch_done so a held fetch_req is not served twice
	assign fetch_go = fetch_req & ~fetch_done_q;
	assign port_start = (grant == gnt_none) & (exe_go | fetch_go);

	always_comb begin
		fetch_rd = '0;
		fetch_rd.rd = 1'b1;
		fetch_rd.addr = fetch_addr;
	end

	assign port_req = exe_go ? (exe_start ? exe_req : exe_req_q) : fetch_rd;

	assign exe_rsp.done = port_rsp.done & (grant == gnt_exe);
	assign exe_rsp.rdata = port_rsp.rdata;
	assign fetch_done = port_rsp.done & (grant == gnt_fetch);
	assign fetch_inst = port_rsp.rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant <= gnt_none;
			exe_pend <= 1'b0;
			fetch_done_q <= 1'b0;
		end else begin
			fetch_done_q <= fetch_done;
			if (port_start) begin
				grant <= exe_go ? gnt_exe : gnt_fetch;
			end else if (port_rsp.done) begin
				grant <= gnt_none;
			end
			if (port_start && exe_go) begin
				exe_pend <= 1'b0;
			end else if (exe_start) begin
				exe_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (exe_start) begin
			exe_req_q <= exe_req;
		end
	end

endmodule

// ==== ram1/ram_uart.sv ====
`timescale 1ns/1ps

module ram_uart (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  mem_pkg::ram_sel_t   sel,
	input  mem_pkg::mem_req_t   req,
	input  mem_pkg::mem_word_t  ram_rdata,
	input  logic                data_ready,
	input  logic                tbre,
	input  logic                tsre,
	output mem_pkg::mem_rsp_t   rsp,
	output mem_pkg::sram_pins_t pins,
	output logic                rdn,
	output logic                wrn
);

	typedef enum logic [2:0] {
		st_idle,
		st_ram,
		st_rd_wait,
		st_rd_strobe,
		st_wr_strobe,
		st_wr_tbre,
		st_wr_tsre
	} state_t;

	state_t state;
	logic strobe_cnt;
	logic uart_done;
	logic uart_drive;
	logic port_start;
	mem_pkg::mem_word_t uart_rdata;
	mem_pkg::mem_word_t uart_wdata;
	mem_pkg::mem_rsp_t port_rsp;
	mem_pkg::sram_pins_t port_pins;

	assign port_start = start & (sel == mem_pkg::sel_ram1);

	sram_port ram1_port_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (port_start),
		.req       (req),
		.ram_rdata (ram_rdata),
		.rsp       (port_rsp),
		.pins      (port_pins)
	);

	// the uart shares the SRAM 1 data bus; chip stays disabled meanwhile
	always_comb begin
		pins = port_pins;
		if (uart_drive) begin
			pins.wdata = uart_wdata;
			pins.drive = 1'b1;
		end
	end

	assign rsp.done = port_rsp.done | uart_done;
	assign rsp.rdata = (state == st_ram) ? port_rsp.rdata : uart_rdata;

	always_ff @(posedge clk) begin
		uart_done <= 1'b0;
		if (!rst_n) begin
			state <= st_idle;
			strobe_cnt <= 1'b0;
			uart_drive <= 1'b0;
			rdn <= 1'b1;
			wrn <= 1'b1;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						strobe_cnt <= 1'b0;
						case (sel)
							mem_pkg::sel_ram1: state <= st_ram;
							mem_pkg::sel_uart_stat: begin
								// bit 0 ready to send, bit 1 byte received
								uart_rdata <= {{(mem_pkg::word_w - 2){1'b0}}, data_ready, tbre & tsre};
								uart_done <= 1'b1;
							end
							mem_pkg::sel_uart_data: begin
								if (req.wr) begin
									uart_wdata <= {8'h00, req.wdata[7:0]};
									uart_drive <= 1'b1;
									wrn <= 1'b0;
									state <= st_wr_strobe;
								end else begin
									state <= st_rd_wait;
								end
							end
							default: state <= st_idle;
						endcase
					end
				end
				st_ram: begin
					if (port_rsp.done) begin
						state <= st_idle;
					end
				end
				st_rd_wait: begin
					if (data_ready) begin
						rdn <= 1'b0;
						state <= st_rd_strobe;
					end
				end
				st_rd_strobe: begin
					strobe_cnt <= 1'b1;
					if (strobe_cnt) begin
						uart_rdata <= {8'h00, ram_rdata[7:0]};
						uart_done <= 1'b1;
						rdn <= 1'b1;
						state <= st_idle;
					end
				end
				st_wr_strobe: begin
					strobe_cnt <= 1'b1;
					if (strobe_cnt) begin
						wrn <= 1'b1;
						state <= st_wr_tbre;
					end
				end
				st_wr_tbre: begin
					// byte stays on the bus until the transmitter takes it
					if (tbre) begin
						uart_drive <= 1'b0;
						state <= st_wr_tsre;
					end
				end
				st_wr_tsre: begin
					if (tsre) begin
						uart_done <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== src/mem_router.sv ====
`timescale 1ns/1ps

module mem_router (
	input  logic               clk,
	input  logic               rst_n,
	input  mem_pkg::mem_req_t  exe_req,
	input  mem_pkg::mem_rsp_t  ram1_rsp,
	input  mem_pkg::mem_rsp_t  ram2_rsp,
	output logic               ram1_start,
	output mem_pkg::ram_sel_t  ram1_sel,
	output logic               ram2_start,
	output logic               hold,
	output mem_pkg::mem_word_t exe_rdata
);

	mem_pkg::ram_sel_t sel;
	mem_pkg::ram_sel_t sel_q;
	mem_pkg::mem_word_t rdata;
	logic mem_op;
	logic busy;
	logic done;
	logic done_q;
	logic start;

	// uart words sit inside the SRAM 1 range, so match them first
	always_comb begin
		if (exe_req.addr == mem_pkg::uart_data_addr) begin
			sel = mem_pkg::sel_uart_data;
		end else if (exe_req.addr == mem_pkg::uart_stat_addr) begin
			sel = mem_pkg::sel_uart_stat;
		end else if (exe_req.addr >= mem_pkg::ram1_base) begin
			sel = mem_pkg::sel_ram1;
		end else begin
			sel = mem_pkg::sel_ram2;
		end
	end

	assign mem_op = exe_req.rd | exe_req.wr;

	// one start per access; done_q keeps the old request from firing again
	assign start = mem_op & ~busy & ~done_q;
	assign ram1_start = start & (sel != mem_pkg::sel_ram2);
	assign ram2_start = start & (sel == mem_pkg::sel_ram2);
	assign ram1_sel = sel;

	assign done = busy & ((sel_q == mem_pkg::sel_ram2) ? ram2_rsp.done : ram1_rsp.done);
	assign rdata = (sel_q == mem_pkg::sel_ram2) ? ram2_rsp.rdata : ram1_rsp.rdata;

	// stall until the cycle after done
	assign hold = mem_op & ~done_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= done;
			if (start) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			sel_q <= sel;
		end
		if (done) begin
			exe_rdata <= rdata;
		end
	end

endmodule

// ==== src/sram_port.sv ====
`timescale 1ns/1ps

module sram_port (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  mem_pkg::mem_req_t   req,
	input  mem_pkg::mem_word_t  ram_rdata,
	output mem_pkg::mem_rsp_t   rsp,
	output mem_pkg::sram_pins_t pins
);

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_strobe
	} state_t;

	state_t state;
	logic [1:0] cnt;
	logic rd_q;
	logic wr_q;

	always_ff @(posedge clk) begin
		rsp.done <= 1'b0;
		if (!rst_n) begin
			state <= st_idle;
			cnt <= '0;
			rd_q <= 1'b0;
			wr_q <= 1'b0;
			pins.en <= 1'b1;
			pins.oe <= 1'b1;
			pins.rw <= 1'b1;
			pins.drive <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					// address and data settle one cycle before en
					if (start) begin
						pins.addr <= mem_pkg::ram_addr_t'(req.addr);
						pins.wdata <= req.wdata;
						pins.drive <= req.wr;
						rd_q <= req.rd;
						wr_q <= req.wr;
						state <= st_setup;
					end
				end
				st_setup: begin
					pins.en <= 1'b0;
					pins.oe <= ~rd_q;
					pins.rw <= ~wr_q;
					cnt <= '0;
					state <= st_strobe;
				end
				st_strobe: begin
					if (cnt == 2'(mem_pkg::sram_cycles - 1)) begin
						// sample while the chip still drives the bus
						rsp.rdata <= ram_rdata;
						rsp.done <= 1'b1;
						pins.en <= 1'b1;
						pins.oe <= 1'b1;
						pins.rw <= 1'b1;
						pins.drive <= 1'b0;
						state <= st_idle;
					end else begin
						cnt <= cnt + 2'd1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== common/mem_pkg.sv ====
package mem_pkg;

	// data path and SRAM widths
	localparam int word_w = 16;
	localparam int ram_addr_w = 18;

	typedef logic [word_w-1:0] mem_word_t;
	typedef logic [ram_addr_w-1:0] ram_addr_t;

	// address map
	localparam mem_word_t uart_data_addr = 16'hBF00;
	localparam mem_word_t uart_stat_addr = 16'hBF01;
	// everything at or above this goes to SRAM 1, below it to SRAM 2
	localparam mem_word_t ram1_base = 16'h8000;

	// en low time of one SRAM access, in cycles
	localparam int sram_cycles = 2;

	typedef struct packed {
		logic      rd;
		logic      wr;
		mem_word_t addr;
		mem_word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic      done;
		mem_word_t rdata;
	} mem_rsp_t;

	// en, oe and rw are active low
	typedef struct packed {
		logic      en;
		logic      oe;
		logic      rw;
		ram_addr_t addr;
		mem_word_t wdata;
		logic      drive;
	} sram_pins_t;

	typedef enum logic [1:0] {
		sel_ram1,
		sel_ram2,
		sel_uart_data,
		sel_uart_stat
	} ram_sel_t;

endpackage
